// ==== source/scan_settings.svh ====
/*
 * global sizing of the scan buffer
 * include wherever memory, word or register widths are needed
 * the packages build their types on these values
 */

`ifndef SCAN_SETTINGS_SVH
`define SCAN_SETTINGS_SVH

// memory address width, 64 words
`define SCAN_ADDR_BITS 6

// data word width
`define SCAN_WORD_BITS 16

// register index width, four registers
`define SCAN_REG_BITS 2

`endif

// ==== source/scan_types_pkg.sv ====
/*
 * buffer data types shared by the memory, the scanner and the top level
 * word and address vectors plus the request struct of one ram port
 */

`include "scan_settings.svh"

package scan_types_pkg;

	// one data word
	typedef logic [`SCAN_WORD_BITS - 1 : 0] word_t;

	// one memory address
	typedef logic [`SCAN_ADDR_BITS - 1 : 0] addr_t;

	// window length, one extra bit so a full-memory window fits
	typedef logic [`SCAN_ADDR_BITS : 0] len_t;

	// request of one ram port
	typedef struct packed {
		// read enable, data returns next cycle
		logic re;
		// write enable
		logic we;
		addr_t addr;
		word_t wdata;
	} ram_req_t;

endpackage

// ==== source/bus_types_pkg.sv ====
/*
 * host bus types for the wishbone classic slave port
 * request from the master, response from the slave, register index
 */

`include "scan_settings.svh"

package bus_types_pkg;

	import scan_types_pkg::*;

	// word address, top bit picks the register window
	typedef logic [`SCAN_ADDR_BITS : 0] wb_adr_t;

	// register index inside the register window
	typedef logic [`SCAN_REG_BITS - 1 : 0] reg_idx_t;

	// master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_adr_t adr;
		word_t dat_w;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic ack;
		word_t dat_r;
	} wb_rsp_t;

endpackage

// ==== source/ram.sv ====
/*
 * two-port word memory with a registered read on each port
 * port 0 serves the host bus, port 1 the scanner
 * read data appears one cycle after the request, zero when not reading
 */

`timescale 1ns/10ps

`include "scan_settings.svh"

module ram
	import scan_types_pkg::*;
#(
	parameter int NUM_PORTS = 2,
	parameter int NUM_WORDS = 2 ** `SCAN_ADDR_BITS
)
(
	input logic in_clk,
	input logic in_rst,

	// one request per port
	input ram_req_t port_req [NUM_PORTS],

	// registered read data per port
	output word_t port_data [NUM_PORTS]
);

	// storage, no reset on contents
	word_t words [NUM_WORDS];

	// read data registers
	word_t data [NUM_PORTS];

	// power-up contents all ones
	initial begin
		for (int i = 0; i < NUM_WORDS; i++) begin
			words[i] = '1;
		end
	end

	// writes, each port on its own enable
	// higher port index wins on a same-address clash
	always_ff @(posedge in_clk) begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (port_req[p].we) begin
				words[port_req[p].addr] <= port_req[p].wdata;
			end
		end
	end

	// reads sample the old word, so a parallel write is not seen yet
	always_ff @(posedge in_clk) begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (in_rst) begin
				data[p] <= '0;
			end else if (port_req[p].re) begin
				data[p] <= words[port_req[p].addr];
			end else begin
				// idle port reads back zero
				data[p] <= '0;
			end
		end
	end

	assign port_data = data;

endmodule

// ==== source/wb_port.sv ====
/*
 * wishbone classic slave in front of the memory and the register block
 * adr top bit clear selects memory, set selects registers
 * writes and register reads ack after one cycle, memory reads after two
 */

`timescale 1ns/10ps

`include "scan_settings.svh"

module wb_port
	import scan_types_pkg::*;
	import bus_types_pkg::*;
(
	input logic in_clk,
	input logic in_rst,

	// host bus
	input wb_req_t wb_req,
	output wb_rsp_t wb_rsp,

	// memory port 0
	output ram_req_t ram_req,
	input word_t ram_data,

	// register block
	output logic reg_we,
	output reg_idx_t reg_idx,
	output word_t reg_wdata,
	input word_t reg_rdata
);

	typedef enum logic [1:0] {
		st_idle,
		st_wait_ram,
		st_ack
	} wb_state_t;

	wb_state_t state;
	wb_state_t state_next;

	// read data held for the ack cycle
	word_t rdata_q;

	// new request, only taken in idle so each cycle gets one access
	logic req_take;
	logic reg_sel;

	assign req_take = (state == st_idle) && wb_req.cyc && wb_req.stb;
	assign reg_sel = wb_req.adr[`SCAN_ADDR_BITS];

	// memory access lasts exactly the idle cycle of the request
	always_comb begin
		ram_req.re = req_take && !reg_sel && !wb_req.we;
		ram_req.we = req_take && !reg_sel && wb_req.we;
		ram_req.addr = wb_req.adr[`SCAN_ADDR_BITS - 1 : 0];
		ram_req.wdata = wb_req.dat_w;
	end

	// register access, low address bits pick the register
	assign reg_we = req_take && reg_sel && wb_req.we;
	assign reg_idx = wb_req.adr[`SCAN_REG_BITS - 1 : 0];
	assign reg_wdata = wb_req.dat_w;

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (req_take) begin
					// memory read waits for the registered ram output
					if (!reg_sel && !wb_req.we) begin
						state_next = st_wait_ram;
					end else begin
						state_next = st_ack;
					end
				end
			end
			st_wait_ram: state_next = st_ack;
			// one ack cycle, then back to sampling stb
			st_ack: state_next = st_idle;
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	// capture register data at request, ram data one cycle later
	always_ff @(posedge in_clk) begin
		if (req_take && reg_sel) begin
			rdata_q <= reg_rdata;
		end else if (state == st_wait_ram) begin
			rdata_q <= ram_data;
		end
	end

	assign wb_rsp.ack = (state == st_ack);
	assign wb_rsp.dat_r = rdata_q;

endmodule

// ==== source/scan_regs.sv ====
/*
 * configuration and status registers of the scanner
 * 0 base, 1 length, 2 control (bit 0 starts), 3 status (bit 0 busy)
 * reads are combinational, the bus slave registers them
 */

`timescale 1ns/10ps

module scan_regs
	import scan_types_pkg::*;
	import bus_types_pkg::*;
(
	input logic in_clk,
	input logic in_rst,

	// register access from the bus slave
	input logic reg_we,
	input reg_idx_t reg_idx,
	input word_t reg_wdata,
	output word_t reg_rdata,

	// scanner side
	input logic busy,
	output addr_t base,
	output len_t length,
	output logic start
);

	localparam reg_idx_t idx_base = 2'd0;
	localparam reg_idx_t idx_length = 2'd1;
	localparam reg_idx_t idx_ctrl = 2'd2;
	localparam reg_idx_t idx_status = 2'd3;

	addr_t base_q;
	len_t length_q;

	// window registers, upper data bits dropped
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			base_q <= '0;
			length_q <= '0;
		end else if (reg_we) begin
			if (reg_idx == idx_base) begin
				base_q <= reg_wdata[$bits(addr_t) - 1 : 0];
			end
			if (reg_idx == idx_length) begin
				length_q <= reg_wdata[$bits(len_t) - 1 : 0];
			end
		end
	end

	// start pulse lasts the write cycle only
	// a running scan ignores it
	assign start = reg_we && (reg_idx == idx_ctrl) && reg_wdata[0] && !busy;

	always_comb begin
		case (reg_idx)
			idx_base: reg_rdata = word_t'(base_q);
			idx_length: reg_rdata = word_t'(length_q);
			// control is write only
			idx_ctrl: reg_rdata = '0;
			idx_status: reg_rdata = word_t'(busy);
			default: reg_rdata = '0;
		endcase
	end

	assign base = base_q;
	assign length = length_q;

endmodule

// ==== source/word_scanner.sv ====
/*
 * streams a window of the memory out through ram port 1
 * start loads base and length, words leave in address order with wrap
 * ready/valid output with a single slot, busy high until the last transfer
 */

`timescale 1ns/10ps

module word_scanner
	import scan_types_pkg::*;
(
	input logic in_clk,
	input logic in_rst,

	// configuration
	input addr_t base,
	input len_t length,
	input logic start,
	output logic busy,

	// memory port 1
	output ram_req_t ram_req,
	input word_t ram_data,

	// output stream
	output logic out_valid,
	output word_t out_data,
	input logic out_ready
);

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_drain
	} scan_state_t;

	scan_state_t state;

	// next word to fetch, words still to fetch
	addr_t next_addr;
	len_t remaining;

	// ram_data carries a fetched word this cycle
	logic in_flight;

	// slot holds a word that stays this cycle
	logic slot_held;
	logic issue;

	assign slot_held = out_valid && !out_ready;

	// fetch only if the slot is sure to be empty when data returns
	assign issue = (state == st_run) && (remaining != '0) && !in_flight && !slot_held;

	always_comb begin
		ram_req.re = issue;
		// read-only port
		ram_req.we = 1'b0;
		ram_req.addr = next_addr;
		ram_req.wdata = '0;
	end

	assign busy = (state != st_idle);

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state <= st_idle;
			next_addr <= '0;
			remaining <= '0;
			in_flight <= 1'b0;
		end else begin
			in_flight <= issue;
			case (state)
				st_idle: begin
					if (start) begin
						next_addr <= base;
						remaining <= length;
						state <= st_run;
					end
				end
				st_run: begin
					if (issue) begin
						// address wraps by width
						next_addr <= next_addr + 1'b1;
						remaining <= remaining - 1'b1;
					end
					if (remaining == '0) begin
						state <= st_drain;
					end
				end
				st_drain: begin
					// last word out or never any word
					if (!in_flight && !slot_held) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// output slot
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			out_valid <= 1'b0;
		end else if (in_flight) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// payload loads only with a returning word
	always_ff @(posedge in_clk) begin
		if (in_flight) begin
			out_data <= ram_data;
		end
	end

endmodule

// ==== source/scan_buffer.sv ====
/*
 * scan buffer top level
 * host fills the memory over wishbone, the scanner streams a window out
 */

`timescale 1ns/10ps

module scan_buffer
	import scan_types_pkg::*;
	import bus_types_pkg::*;
(
	input logic in_clk,
	input logic in_rst,

	// host bus
	input wb_req_t wb_req,
	output wb_rsp_t wb_rsp,

	// output stream
	output logic out_valid,
	output word_t out_data,
	input logic out_ready
);

	// ram ports, 0 host, 1 scanner
	ram_req_t ram_req [2];
	word_t ram_data [2];

	// register block links
	logic reg_we;
	reg_idx_t reg_idx;
	word_t reg_wdata;
	word_t reg_rdata;

	// scanner configuration
	addr_t base;
	len_t length;
	logic start;
	logic busy;

	wb_port u_wb_port (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.ram_req (ram_req[0]),
		.ram_data (ram_data[0]),
		.reg_we (reg_we),
		.reg_idx (reg_idx),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata)
	);

	scan_regs u_scan_regs (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.reg_we (reg_we),
		.reg_idx (reg_idx),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.busy (busy),
		.base (base),
		.length (length),
		.start (start)
	);

	word_scanner u_word_scanner (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.base (base),
		.length (length),
		.start (start),
		.busy (busy),
		.ram_req (ram_req[1]),
		.ram_data (ram_data[1]),
		.out_valid (out_valid),
		.out_data (out_data),
		.out_ready (out_ready)
	);

	ram u_ram (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.port_req (ram_req),
		.port_data (ram_data)
	);

endmodule

// ==== test/scan_buffer_props.sv ====
/*
 * protocol assertions, bound into the scan buffer top level
 * wishbone ack length, stream hold under back-pressure, valid only while busy
 */

`timescale 1ns/10ps

module scan_buffer_props
	import scan_types_pkg::*;
	import bus_types_pkg::*;
(
	input logic in_clk,
	input logic in_rst,
	input wb_rsp_t wb_rsp,
	input logic out_valid,
	input word_t out_data,
	input logic out_ready,
	input logic busy
);

	// failures so far, watched by the testbench
	int fail_count = 0;

	// ack lasts exactly one cycle
	ack_single: assert property (
		@(posedge in_clk) disable iff (in_rst) wb_rsp.ack |=> !wb_rsp.ack
	) else begin
		fail_count++;
		$error("wishbone ack high for two cycles in a row");
	end

	// stalled word stays put
	stream_hold: assert property (
		@(posedge in_clk) disable iff (in_rst)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data))
	) else begin
		fail_count++;
		$error("stream valid or data changed while stalled");
	end

	// no stream word outside a scan
	valid_busy: assert property (
		@(posedge in_clk) disable iff (in_rst) !(out_valid && !busy)
	) else begin
		fail_count++;
		$error("stream valid while the scanner is idle");
	end

endmodule

// ==== test/scan_buffer_tb.sv ====
/*
 * testbench of the scan buffer
 * drives the wishbone host port, mirrors memory writes in a reference array
 * and checks every stream word against the expected window contents
 */

`timescale 1ns/10ps

`include "scan_settings.svh"

module scan_buffer_tb
	import scan_types_pkg::*;
	import bus_types_pkg::*;
();

	localparam int num_words = 2 ** `SCAN_ADDR_BITS;
	localparam int half_period = 50;
	// all tests need well under 2000 cycles, the rest is margin
	localparam int timeout_cycles = 20000;

	logic in_clk;
	logic in_rst;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic out_valid;
	word_t out_data;
	logic out_ready;

	// reference memory and which words the host wrote
	word_t ref_mem [num_words];
	bit written [num_words];

	// window of the running scan as the checker sees it
	addr_t scan_base;
	len_t scan_len;
	int rx_count;
	bit random_ready;
	string test_name;
	int cycles;

	scan_buffer u_scan_buffer (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.out_valid (out_valid),
		.out_data (out_data),
		.out_ready (out_ready)
	);

	bind scan_buffer scan_buffer_props u_scan_buffer_props (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.wb_rsp (wb_rsp),
		.out_valid (out_valid),
		.out_data (out_data),
		.out_ready (out_ready),
		.busy (busy)
	);

	initial begin
		in_clk = 1'b0;
		forever #half_period in_clk = ~in_clk;
	end

	// word at base plus index, address wraps over the whole memory
	function automatic word_t expected_word(input addr_t b, input int idx);
		int a;
		a = (int'(b) + idx) % num_words;
		return ref_mem[a];
	endfunction

	// register window sits above the memory window
	function automatic wb_adr_t reg_adr(input int idx);
		return wb_adr_t'(num_words + idx);
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string what, input word_t expected,
		input word_t actual);
		string line;
		if (expected !== actual) begin
			line = $sformatf("** Error: %s, %s: expected %0h, actual %0h",
				test_name, what, expected, actual);
			fail_run(line);
		end
	endtask

	// wait for ack, take read data, end on the edge that closes the ack cycle
	task automatic wait_ack(output word_t data);
		do begin
			@(negedge in_clk);
		end while (!wb_rsp.ack);
		data = wb_rsp.dat_r;
		@(posedge in_clk);
	endtask

	task automatic wb_write(input wb_adr_t adr, input word_t data);
		word_t unused;
		@(posedge in_clk);
		wb_req.cyc <= 1'b1;
		wb_req.stb <= 1'b1;
		wb_req.we <= 1'b1;
		wb_req.adr <= adr;
		wb_req.dat_w <= data;
		wait_ack(unused);
		wb_req.cyc <= 1'b0;
		wb_req.stb <= 1'b0;
		wb_req.we <= 1'b0;
		// memory write takes effect at ack
		if (!adr[`SCAN_ADDR_BITS]) begin
			ref_mem[adr[`SCAN_ADDR_BITS - 1 : 0]] = data;
			written[adr[`SCAN_ADDR_BITS - 1 : 0]] = 1'b1;
		end
	endtask

	task automatic wb_read(input wb_adr_t adr, output word_t data);
		@(posedge in_clk);
		wb_req.cyc <= 1'b1;
		wb_req.stb <= 1'b1;
		wb_req.we <= 1'b0;
		wb_req.adr <= adr;
		wait_ack(data);
		wb_req.cyc <= 1'b0;
		wb_req.stb <= 1'b0;
	endtask

	// configure the window, arm the checker, then start
	task automatic start_scan(input addr_t b, input len_t l, input bit bp);
		wb_write(reg_adr(0), word_t'(b));
		wb_write(reg_adr(1), word_t'(l));
		scan_base = b;
		scan_len = l;
		rx_count = 0;
		random_ready = bp;
		wb_write(reg_adr(2), 16'h0001);
	endtask

	// poll status until busy drops, then the whole window must be in
	task automatic finish_scan();
		word_t status;
		do begin
			wb_read(reg_adr(3), status);
		end while (status[0]);
		random_ready = 1'b0;
		check_value("word count", word_t'(scan_len), word_t'(rx_count));
		wb_read(reg_adr(3), status);
		check_value("status after scan", 0, status);
	endtask

	task automatic run_scan(input addr_t b, input len_t l, input bit bp);
		start_scan(b, l, bp);
		finish_scan();
	endtask

	// sink ready, about half the cycles under back-pressure
	always @(posedge in_clk) begin
		if (random_ready) begin
			out_ready <= ($urandom % 2) == 1;
		end else begin
			out_ready <= 1'b1;
		end
	end

	// transfer happens at the next rising edge
	always @(negedge in_clk) begin
		if (!in_rst && out_valid && out_ready) begin
			if (rx_count >= int'(scan_len)) begin
				fail_run("stream sent a word beyond the window length");
			end else begin
				check_value("stream word", expected_word(scan_base, rx_count), out_data);
				rx_count++;
			end
		end
	end

	always @(negedge in_clk) begin
		if (u_scan_buffer.u_scan_buffer_props.fail_count != 0) begin
			fail_run("a protocol assertion failed");
		end
	end

	always @(posedge in_clk) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			fail_run("timeout, the run did not finish within the cycle limit");
		end
	end

	initial begin
		word_t value;
		addr_t a;
		int order [num_words];
		int j;
		int tmp;
		void'($urandom(32'hbb7f));
		in_rst = 1'b1;
		wb_req = '0;
		out_ready = 1'b0;
		random_ready = 1'b0;
		scan_base = '0;
		scan_len = '0;
		rx_count = 0;
		cycles = 0;
		test_name = "reset";
		// memory powers up all ones
		for (int i = 0; i < num_words; i++) begin
			ref_mem[i] = '1;
			written[i] = 1'b0;
		end
		repeat (5) @(posedge in_clk);
		in_rst <= 1'b0;

		test_name = "register readback";
		wb_read(reg_adr(3), value);
		check_value("status after reset", 0, value);
		wb_read(reg_adr(0), value);
		check_value("base after reset", 0, value);
		wb_read(reg_adr(1), value);
		check_value("length after reset", 0, value);
		wb_write(reg_adr(0), 16'h002a);
		wb_write(reg_adr(1), 16'h0027);
		wb_read(reg_adr(0), value);
		check_value("base", 16'h002a, value);
		wb_read(reg_adr(1), value);
		check_value("length", 16'h0027, value);
		wb_read(reg_adr(2), value);
		check_value("control", 0, value);

		test_name = "memory access";
		// random addresses, so some words stay unwritten
		for (int i = 0; i < num_words; i++) begin
			a = addr_t'($urandom);
			wb_write(wb_adr_t'(a), word_t'($urandom));
		end
		for (int i = 0; i < num_words; i++) begin
			order[i] = i;
		end
		for (int i = num_words - 1; i > 0; i--) begin
			j = int'($urandom % (i + 1));
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < num_words; i++) begin
			wb_read(wb_adr_t'(order[i]), value);
			if (!written[order[i]]) begin
				check_value("unwritten word", 16'hffff, value);
			end
			check_value("memory word", ref_mem[order[i]], value);
		end

		test_name = "basic scan";
		run_scan(10, 20, 1'b0);

		test_name = "wrap and edge lengths";
		run_scan(60, 8, 1'b0);
		run_scan(33, 64, 1'b0);
		run_scan(17, 0, 1'b0);

		test_name = "back-pressure";
		run_scan(50, 64, 1'b1);
		run_scan(7, 30, 1'b1);

		test_name = "start while busy";
		start_scan(3, 64, 1'b0);
		// new base lands in the register only
		wb_write(reg_adr(0), 16'd40);
		wb_read(reg_adr(3), value);
		check_value("busy mid-scan", 1, value);
		wb_write(reg_adr(2), 16'h0001);
		finish_scan();

		// assertions on the last bus cycle settle a cycle later
		repeat (3) @(posedge in_clk);
		if (u_scan_buffer.u_scan_buffer_props.fail_count != 0) begin
			fail_run("a protocol assertion failed");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

// ==== list.f ====
+incdir+source
source/scan_types_pkg.sv
source/bus_types_pkg.sv
source/ram.sv
source/wb_port.sv
source/scan_regs.sv
source/word_scanner.sv
source/scan_buffer.sv
test/scan_buffer_props.sv
test/scan_buffer_tb.sv

// ==== Makefile ====
# Verilator build and run of the scan buffer testbench
# override any variable on the command line, e.g. make TOP=scan_buffer_tb

VERILATOR ?= verilator
TOP ?= scan_buffer_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
RUN_FLAGS ?= +verilator+error+limit+100
PASS_TEXT ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# pass only when the simulation output holds the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)
